//--- logic/qla_macros.svh
// --------------------------------------
// shared constants for the motor channel core
// include wherever widths, offsets or limits are needed
// --------------------------------------
`ifndef QLA_MACROS_SVH
`define QLA_MACROS_SVH

// ---------------------------------------
// bus and data widths
// ---------------------------------------
`define NUM_AXES         4          // motor channels 1..4
`define DATA_W           32         // register data
`define ADDR_W           16         // register address
`define SAMPLE_W         16         // adc and dac words

// ---------------------------------------
// address map, block in [15:12], chan [7:4], offset [3:0]
// ---------------------------------------
`define ADDR_MAIN        0          // main register block
`define OFF_ADC_DATA     0          // pot | cur
`define OFF_DAC_CTRL     1          // commanded current
`define OFF_MOTOR_STATUS 12         // pin, safety and command

// ---------------------------------------
// safety check limits
// ---------------------------------------
`define MIDSCALE         16'h8000   // zero current code
`define SAFETY_MARGIN    16'h0200   // allowed excess, counts
`define SAFETY_LIMIT     4          // consecutive bad samples to trip

`endif

//--- logic/qla_reg_pkg.sv
// --------------------------------------
// register map types for the board register bus
// address fields, offsets and the write bus bundle
// --------------------------------------
`include "qla_macros.svh"

package qla_reg_pkg;

    // ---------------------------------------
    // address block code in addr[15:12]
    // ---------------------------------------
    // only the main block is decoded
    typedef enum logic [3:0] {
        BLK_MAIN = 4'(`ADDR_MAIN)
    } addr_block_e;

    // ---------------------------------------
    // per channel offset in addr[3:0]
    // ---------------------------------------
    typedef enum logic [3:0] {
        OFF_ADC    = 4'(`OFF_ADC_DATA),     // adc data read
        OFF_DAC    = 4'(`OFF_DAC_CTRL),     // current command r/w
        OFF_STATUS = 4'(`OFF_MOTOR_STATUS)  // motor status read
    } reg_off_e;

    // write bus as seen from the link layer
    // 1 + 1 + 16 + 32 = 50 bits
    typedef struct packed {
        logic                 wen;      // quadlet or block word write
        logic                 blk_wen;  // end of block write kicks the dac
        logic [`ADDR_W-1:0]   waddr;    // write address
        logic [`DATA_W-1:0]   wdata;    // write data
    } reg_wr_t;

endpackage

//--- logic/qla_motor_pkg.sv
// --------------------------------------
// motor data types shared by the channel blocks
// per axis words, adc feedback bundle, safety state
// --------------------------------------
`include "qla_macros.svh"

package qla_motor_pkg;

    // ---------------------------------------
    // per axis data
    // ---------------------------------------

    // one word per axis, index 0 is channel 1
    // 4 x 16 = 64 bits
    typedef logic [`NUM_AXES-1:0][`SAMPLE_W-1:0] axis_word_t;

    // one bit per axis, amp pins and disables
    typedef logic [`NUM_AXES-1:0] axis_mask_t;

    // ---------------------------------------
    // adc feedback
    // ---------------------------------------

    // one complete conversion, current and pot for every axis
    // 128 bits, cur in the upper half
    typedef struct packed {
        axis_word_t cur;    // motor current
        axis_word_t pot;    // pot position
    } adc_fb_t;

    // ---------------------------------------
    // safety check
    // ---------------------------------------

    // per axis state of the overcurrent check
    typedef enum logic [1:0] {
        SAFE_ARMED    = 2'd0,   // no offending sample pending
        SAFE_COUNTING = 2'd1,   // run of offending samples
        SAFE_TRIPPED  = 2'd2    // amp disabled until a clear
    } safety_state_e;

    // 2'd3 not used, decodes as tripped nowhere

endpackage

//--- logic/cur_cmd_bank.sv
// --------------------------------------
// commanded current bank, one word per axis
// written through OFF_DAC_CTRL, kicks the dac serializer
// --------------------------------------
`timescale 1ns/100ps
`include "qla_macros.svh"

module cur_cmd_bank (
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  qla_reg_pkg::reg_wr_t    wr,             // register write bus
    input  logic                    dac_busy,       // serializer shifting
    output qla_motor_pkg::axis_word_t cur_cmd,      // commands, to dac and safety
    output logic                    dac_data_ready  // one cycle update strobe
);

    // ---------------------------------------
    // write address decode
    // ---------------------------------------
    logic [3:0] wr_blk;     // addr[15:12]
    logic [3:0] wr_chan;    // addr[7:4], 1 based
    logic [3:0] wr_off;     // addr[3:0]
    logic       wr_hit;     // write lands on a dac command
    logic       cur_cmd_req;    // pending dac update
    logic       req_issue;      // serializer takes it this cycle

    assign wr_blk  = wr.waddr[15:12];
    assign wr_chan = wr.waddr[7:4];
    assign wr_off  = wr.waddr[3:0];

    // channel 0 is the board register set, skip it and anything past the last axis
    assign wr_hit = (wr_blk == qla_reg_pkg::BLK_MAIN) &&
                    (wr_chan != 4'd0) && (wr_chan <= 4'(`NUM_AXES)) &&
                    (wr_off == qla_reg_pkg::OFF_DAC);

    assign req_issue = cur_cmd_req & ~dac_busy;

    // ---------------------------------------
    // command words
    // ---------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cur_cmd <= '0;
        end else begin
            for (int i = 0; i < `NUM_AXES; i++) begin
                if (wr_hit && wr.wen && (wr_chan == 4'(i + 1)))
                    cur_cmd[i] <= wr.wdata[`SAMPLE_W-1:0];  // low half only
            end
        end
    end

    // ---------------------------------------
    // update request, waits out dac_busy
    // ---------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cur_cmd_req    <= 1'b0;
            dac_data_ready <= 1'b0;
        end else begin
            // a write landing now is already in cur_cmd when ready rises
            if (req_issue)
                cur_cmd_req <= 1'b0;
            else if (wr_hit)
                cur_cmd_req <= cur_cmd_req | wr.blk_wen;    // merge with pending
            dac_data_ready <= req_issue;                    // registered pulse
        end
    end

endmodule

//--- logic/board_feedback.sv
// --------------------------------------
// adc feedback capture and amp pin synchronizer
// holds the last full conversion for readers and safety
// --------------------------------------
`timescale 1ns/100ps
`include "qla_macros.svh"

module board_feedback (
    input  logic                        sysclk,
    input  logic                        rst_n,
    input  logic                        adc_strobe,         // conversion complete
    input  qla_motor_pkg::adc_fb_t      adc_data,           // from adc engine
    input  qla_motor_pkg::axis_mask_t   amp_disable_pin,    // async, from amps
    output qla_motor_pkg::adc_fb_t      fb,                 // stable sample set
    output logic                        fb_strobe,          // fb just updated
    output qla_motor_pkg::axis_mask_t   amp_disable_sync    // pins in sysclk
);

    qla_motor_pkg::axis_mask_t pin_meta;    // first sync stage

    // ---------------------------------------
    // adc sample hold
    // ---------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            fb        <= '0;
            fb_strobe <= 1'b0;
        end else begin
            if (adc_strobe)
                fb <= adc_data;     // whole set at once, no torn reads
            fb_strobe <= adc_strobe;    // marks new fb for the safety check
        end
    end

    // ---------------------------------------
    // amp disable pins, two flop sync
    // ---------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            pin_meta         <= '0;
            amp_disable_sync <= '0;
        end else begin
            pin_meta         <= amp_disable_pin;
            amp_disable_sync <= pin_meta;
        end
    end

endmodule

//--- logic/safety_monitor.sv
// --------------------------------------
// per axis overcurrent check
// trips an amp when feedback runs well past the command
// --------------------------------------
`timescale 1ns/100ps
`include "qla_macros.svh"

module safety_monitor (
    input  logic                        sysclk,
    input  logic                        rst_n,
    input  qla_motor_pkg::axis_word_t   cur_cmd,            // commanded current
    input  qla_motor_pkg::axis_word_t   fb_cur,             // measured current
    input  logic                        fb_strobe,          // new sample in fb_cur
    input  logic                        pwr_enable_cmd,     // global clear
    input  qla_motor_pkg::axis_mask_t   amp_enable_cmd,     // per axis clear
    output qla_motor_pkg::axis_mask_t   safety_amp_disable  // latched disables
);

    localparam int CNT_W = $clog2(`SAFETY_LIMIT) + 1;

    qla_motor_pkg::safety_state_e   state [`NUM_AXES];
    logic [CNT_W-1:0]               bad_cnt [`NUM_AXES];   // consecutive offenders
    logic [`SAMPLE_W-1:0]           cmd_dev [`NUM_AXES];
    logic [`SAMPLE_W-1:0]           fb_dev  [`NUM_AXES];
    logic [`SAMPLE_W+1:0]           allow   [`NUM_AXES];   // 2*cmd_dev + margin
    logic [`NUM_AXES-1:0]           offend;
    qla_motor_pkg::axis_mask_t      clr;

    // distance from the zero current code
    function automatic logic [`SAMPLE_W-1:0] deviation(input logic [`SAMPLE_W-1:0] x);
        if (x >= `MIDSCALE)
            return x - `MIDSCALE;
        else
            return `MIDSCALE - x;
    endfunction

    // ---------------------------------------
    // sample compare
    // ---------------------------------------
    always_comb begin
        for (int i = 0; i < `NUM_AXES; i++) begin
            cmd_dev[i] = deviation(cur_cmd[i]);
            fb_dev[i]  = deviation(fb_cur[i]);
            allow[i]   = {1'b0, cmd_dev[i], 1'b0} + (`SAMPLE_W+2)'(`SAFETY_MARGIN);
            offend[i]  = {2'b00, fb_dev[i]} > allow[i];  // extra bits, no overflow
        end
    end

    assign clr = {`NUM_AXES{pwr_enable_cmd}} | amp_enable_cmd;

    // ---------------------------------------
    // per axis state machines
    // ---------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_AXES; i++) begin
                state[i]   <= qla_motor_pkg::SAFE_ARMED;
                bad_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_AXES; i++) begin
                if (clr[i]) begin   // clear beats a trip
                    state[i]   <= qla_motor_pkg::SAFE_ARMED;
                    bad_cnt[i] <= '0;
                end else if (fb_strobe && (state[i] != qla_motor_pkg::SAFE_TRIPPED)) begin
                    if (!offend[i]) begin
                        state[i]   <= qla_motor_pkg::SAFE_ARMED;   // clean sample
                        bad_cnt[i] <= '0;
                    end else if (bad_cnt[i] == CNT_W'(`SAFETY_LIMIT - 1)) begin
                        state[i]   <= qla_motor_pkg::SAFE_TRIPPED;
                        bad_cnt[i] <= '0;
                    end else begin
                        state[i]   <= qla_motor_pkg::SAFE_COUNTING;
                        bad_cnt[i] <= bad_cnt[i] + 1'b1;
                    end
                end
            end
        end
    end

    // disable straight off the state flops
    always_comb begin
        for (int i = 0; i < `NUM_AXES; i++)
            safety_amp_disable[i] = (state[i] == qla_motor_pkg::SAFE_TRIPPED);
    end

endmodule

//--- logic/chan_read_mux.sv
// --------------------------------------
// channel read path for adc, dac command and status
// combinational, zero latency from reg_raddr
// --------------------------------------
`timescale 1ns/100ps
`include "qla_macros.svh"

module chan_read_mux (
    input  logic [`ADDR_W-1:0]          reg_raddr,
    input  qla_motor_pkg::axis_word_t   cur_cmd,
    input  qla_motor_pkg::adc_fb_t      fb,
    input  qla_motor_pkg::axis_mask_t   amp_disable_sync,   // pins, active high
    input  qla_motor_pkg::axis_mask_t   safety_amp_disable,
    output logic [`DATA_W-1:0]          reg_rdata
);

    localparam int IDX_W = $clog2(`NUM_AXES);

    logic [3:0]         rd_blk;     // addr[15:12]
    logic [3:0]         rd_chan;    // addr[7:4]
    logic [3:0]         rd_off;     // addr[3:0]
    logic               rd_valid;   // main block, real axis
    logic [IDX_W-1:0]   rd_idx;     // 0 based axis

    assign rd_blk  = reg_raddr[15:12];
    assign rd_chan = reg_raddr[7:4];
    assign rd_off  = reg_raddr[3:0];
    assign rd_idx  = IDX_W'(rd_chan - 4'd1);

    assign rd_valid = (rd_blk == qla_reg_pkg::BLK_MAIN) &&
                      (rd_chan != 4'd0) && (rd_chan <= 4'(`NUM_AXES));

    // ---------------------------------------
    // word assembly by offset
    // ---------------------------------------
    always_comb begin
        reg_rdata = '0;     // unmapped reads give zero
        if (rd_valid) begin
            case (rd_off)
                qla_reg_pkg::OFF_ADC:
                    reg_rdata = {fb.pot[rd_idx], fb.cur[rd_idx]};
                qla_reg_pkg::OFF_DAC:
                    reg_rdata = {16'd0, cur_cmd[rd_idx]};
                qla_reg_pkg::OFF_STATUS:
                    // [28] amp enabled, [27] safety trip, [15:0] command
                    reg_rdata = {3'b000, ~amp_disable_sync[rd_idx],
                                 safety_amp_disable[rd_idx], 11'd0, cur_cmd[rd_idx]};
                default:
                    reg_rdata = '0;
            endcase
        end
    end

endmodule

//--- logic/qla_motor_top.sv
// --------------------------------------
// motor channel core, top level
// register writes in, dac commands and reads out
// --------------------------------------
`timescale 1ns/100ps
`include "qla_macros.svh"

module qla_motor_top (
    input  logic                        sysclk,
    input  logic                        rst_n,
    input  qla_reg_pkg::reg_wr_t        wr,                 // register write bus
    input  logic [`ADDR_W-1:0]          reg_raddr,
    input  logic                        dac_busy,           // dac serializer busy
    input  logic                        adc_strobe,         // adc conversion done
    input  qla_motor_pkg::adc_fb_t      adc_data,
    input  qla_motor_pkg::axis_mask_t   amp_disable_pin,    // async amp pins
    input  logic                        pwr_enable_cmd,     // clears all trips
    input  qla_motor_pkg::axis_mask_t   amp_enable_cmd,     // clears one trip
    output logic [`DATA_W-1:0]          reg_rdata,
    output qla_motor_pkg::axis_word_t   dac_cmd,            // also feeds safety/read
    output logic                        dac_data_ready,     // dac update strobe
    output qla_motor_pkg::axis_mask_t   safety_amp_disable
);

    // ---------------------------------------
    // internal nets
    // ---------------------------------------
    qla_motor_pkg::adc_fb_t     fb;                 // held adc sample set
    logic                       fb_strobe;          // fb refreshed
    qla_motor_pkg::axis_mask_t  amp_disable_sync;   // pins after sync

    // command bank, drives dac_cmd straight out
    cur_cmd_bank u_cmd (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .wr             (wr),
        .dac_busy       (dac_busy),
        .cur_cmd        (dac_cmd),
        .dac_data_ready (dac_data_ready)
    );

    // adc capture + pin sync, side by side with the bank
    board_feedback u_fb (
        .sysclk           (sysclk),
        .rst_n            (rst_n),
        .adc_strobe       (adc_strobe),
        .adc_data         (adc_data),
        .amp_disable_pin  (amp_disable_pin),
        .fb               (fb),
        .fb_strobe        (fb_strobe),
        .amp_disable_sync (amp_disable_sync)
    );

    safety_monitor u_safe (
        .sysclk             (sysclk),
        .rst_n              (rst_n),
        .cur_cmd            (dac_cmd),
        .fb_cur             (fb.cur),   // current half only
        .fb_strobe          (fb_strobe),
        .pwr_enable_cmd     (pwr_enable_cmd),
        .amp_enable_cmd     (amp_enable_cmd),
        .safety_amp_disable (safety_amp_disable)
    );

    chan_read_mux u_rd (
        .reg_raddr          (reg_raddr),
        .cur_cmd            (dac_cmd),
        .fb                 (fb),
        .amp_disable_sync   (amp_disable_sync),
        .safety_amp_disable (safety_amp_disable),
        .reg_rdata          (reg_rdata)
    );

endmodule

//--- dv/qla_motor_assert.sv
// ----------------------------------------
// protocol checks on the dac strobe and the safety disables
// bound into qla_motor_top
// ----------------------------------------
`timescale 1ns/100ps
`include "qla_macros.svh"

module qla_motor_assert (
    input logic                         sysclk,
    input logic                         rst_n,
    input logic                         dac_busy,
    input logic                         dac_data_ready,
    input logic                         pwr_enable_cmd,
    input qla_motor_pkg::axis_mask_t    amp_enable_cmd,
    input qla_motor_pkg::axis_mask_t    safety_amp_disable
);

    // update strobe is a single cycle pulse
    a_ready_pulse: assert property (@(posedge sysclk) disable iff (!rst_n)
        dac_data_ready |=> !dac_data_ready)
        else $error("dac_data_ready high two cycles running");

    // busy holds back any pending request
    a_ready_busy: assert property (@(posedge sysclk) disable iff (!rst_n)
        dac_busy |=> !dac_data_ready)
        else $error("dac_data_ready rose right after dac_busy was high");

    // a trip only ends through the global or per axis enable
    for (genvar i = 0; i < `NUM_AXES; i++) begin : g_axis
        a_trip_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
            (safety_amp_disable[i] && !pwr_enable_cmd && !amp_enable_cmd[i])
                |=> safety_amp_disable[i])
            else $error("safety disable on axis %0d fell without a clear", i);
    end

endmodule

bind qla_motor_top qla_motor_assert u_assert (
    .sysclk             (sysclk),
    .rst_n              (rst_n),
    .dac_busy           (dac_busy),
    .dac_data_ready     (dac_data_ready),
    .pwr_enable_cmd     (pwr_enable_cmd),
    .amp_enable_cmd     (amp_enable_cmd),
    .safety_amp_disable (safety_amp_disable)
);

//--- dv/tb_qla_motor.sv
// ----------------------------------------
// testbench for the motor channel core
// random register, adc and pin traffic checked against a cycle model
// ----------------------------------------
`timescale 1ns/100ps
`include "qla_macros.svh"

module tb_qla_motor;

    localparam int N_CYCLES = 2000;             // stimulus cycles with a hot second half
    localparam int LIMIT    = 2 * N_CYCLES;     // watchdog limit in clocks

    logic                       sysclk;
    logic                       rst_n;
    qla_reg_pkg::reg_wr_t       wr;
    logic [`ADDR_W-1:0]         reg_raddr;
    logic                       dac_busy;
    logic                       adc_strobe;
    qla_motor_pkg::adc_fb_t     adc_data;
    qla_motor_pkg::axis_mask_t  amp_disable_pin;
    logic                       pwr_enable_cmd;
    qla_motor_pkg::axis_mask_t  amp_enable_cmd;
    logic [`DATA_W-1:0]         reg_rdata;
    qla_motor_pkg::axis_word_t  dac_cmd;
    logic                       dac_data_ready;
    qla_motor_pkg::axis_mask_t  safety_amp_disable;

    // ----------------------------------------
    // reference model state
    // ----------------------------------------
    qla_motor_pkg::axis_word_t  m_cmd       = '0;     // commanded currents
    logic                       m_req       = 1'b0;   // pending dac update
    logic                       m_ready     = 1'b0;
    qla_motor_pkg::adc_fb_t     m_fb        = '0;
    logic                       m_fb_strobe = 1'b0;
    qla_motor_pkg::axis_mask_t  m_meta      = '0;     // first pin stage
    qla_motor_pkg::axis_mask_t  m_sync      = '0;     // second pin stage
    qla_motor_pkg::axis_mask_t  m_trip      = '0;
    int                         m_cnt [`NUM_AXES] = '{default: 0};   // offending run

    integer                     seed = 32'ha137_404f;
    int                         cycle_cnt;
    int                         ready_errs = 0;
    int                         cmd_errs = 0;
    int                         dis_errs = 0;
    int                         rd_errs = 0;
    int                         other_errs = 0;
    int                         pulse_cnt = 0;
    qla_motor_pkg::axis_mask_t  trips_seen = '0;

    qla_motor_top DUT (.*);

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;
    end

    // watchdog on the clock count
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < LIMIT) begin
            @(posedge sysclk);
            cycle_cnt++;
        end
        $display("timeout: run still going after %0d clock cycles", LIMIT);
        $display("Test failed");
        $finish;
    end

    // distance from the zero current code in plain int math
    function automatic int abs_dev(input logic [15:0] x);
        int v;
        v = int'({16'h0000, x}) - int'(`MIDSCALE);
        return (v < 0) ? -v : v;
    endfunction

    // mostly real channels with some channel 0 or 5, other blocks and stray offsets
    function automatic logic [15:0] pick_addr();
        logic [31:0] r;
        logic [3:0]  blk;
        logic [3:0]  off;
        r   = $random(seed);
        blk = (r[17:16] == 2'b00) ? r[21:18] : 4'(`ADDR_MAIN);
        case (r[10:8])
            3'd0, 3'd1, 3'd2: off = 4'(`OFF_DAC_CTRL);
            3'd3, 3'd4:       off = 4'(`OFF_ADC_DATA);
            3'd5:             off = 4'(`OFF_MOTOR_STATUS);
            default:          off = r[15:12];
        endcase
        return {blk, r[25:22], 4'(r[7:0] % 8'd6), off};
    endfunction

    // what a read of address a returns from the model
    function automatic logic [31:0] exp_read(input logic [15:0] a);
        int          i;
        logic [3:0]  ch;
        logic [31:0] w;
        ch = a[7:4];
        i  = int'(ch) - 1;
        w  = 32'h0;
        if (a[15:12] != 4'(`ADDR_MAIN) || ch == 4'd0 || ch > 4'(`NUM_AXES))
            return 32'h0;
        case (a[3:0])
            4'(`OFF_ADC_DATA): w = {m_fb.pot[i], m_fb.cur[i]};
            4'(`OFF_DAC_CTRL): w = {16'h0000, m_cmd[i]};
            4'(`OFF_MOTOR_STATUS): begin
                w[28]   = ~m_sync[i];   // amp enabled
                w[27]   = m_trip[i];
                w[15:0] = m_cmd[i];
            end
            default: w = 32'h0;
        endcase
        return w;
    endfunction

    // falling edge inputs that lean toward trips in the hot phase
    task automatic drive_inputs(input logic hot);
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] a;
        r = $random(seed);
        d = $random(seed);
        e = $random(seed);
        wr.wen     = r[0];
        wr.blk_wen = r[1];
        wr.waddr   = pick_addr();
        wr.wdata   = hot ? {d[31:16], 16'h7f80 + {8'h00, d[7:0]}} : d;  // near zero current
        dac_busy   = r[2];
        adc_strobe = hot ? (r[6:5] == 2'b00) : (r[8:6] == 3'b000);
        pwr_enable_cmd = hot ? (r[15:10] == 6'd0) : (r[12:10] == 3'd0);
        if (r[19:17] == 3'd0)
            amp_disable_pin = r[23:20];
        for (int i = 0; i < `NUM_AXES; i++) begin
            a = $random(seed);
            amp_enable_cmd[i] = hot ? (e[i*5 +: 5] == 5'd0) : (e[i*3 +: 3] == 3'd0);
            adc_data.pot[i]   = a[31:16];
            if (!hot)
                adc_data.cur[i] = a[15:0];
            else if (a[2:0] != 3'd0)
                adc_data.cur[i] = {4'h0, a[15:4]};          // far below zero so it offends
            else
                adc_data.cur[i] = 16'h8000 + {8'h00, a[10:3]};  // clean
        end
        reg_raddr = pick_addr();
    endtask

    // model state after the next rising edge
    task automatic step_model();
        logic [3:0] ch;
        logic       hit;
        logic       issue;
        // safety runs on the old command and feedback
        for (int i = 0; i < `NUM_AXES; i++) begin
            if (pwr_enable_cmd || amp_enable_cmd[i]) begin
                m_trip[i] = 1'b0;
                m_cnt[i]  = 0;
            end else if (m_fb_strobe && !m_trip[i]) begin
                if (abs_dev(m_fb.cur[i]) <= 2 * abs_dev(m_cmd[i]) + int'(`SAFETY_MARGIN)) begin
                    m_cnt[i] = 0;
                end else if (m_cnt[i] + 1 == `SAFETY_LIMIT) begin
                    m_trip[i] = 1'b1;
                    m_cnt[i]  = 0;
                end else begin
                    m_cnt[i]++;
                end
            end
        end
        m_sync      = m_meta;
        m_meta      = amp_disable_pin;
        m_fb_strobe = adc_strobe;
        if (adc_strobe)
            m_fb = adc_data;
        ch    = wr.waddr[7:4];
        hit   = (wr.waddr[15:12] == 4'(`ADDR_MAIN)) && (ch >= 4'd1) &&
                (ch <= 4'(`NUM_AXES)) && (wr.waddr[3:0] == 4'(`OFF_DAC_CTRL));
        issue = m_req && !dac_busy;
        m_ready = issue;
        if (issue)
            m_req = 1'b0;       // a request on the issue cycle rides along
        else if (hit && wr.blk_wen)
            m_req = 1'b1;
        if (hit && wr.wen)
            m_cmd[int'(ch) - 1] = wr.wdata[15:0];
    endtask

    task automatic check_outputs();
        logic [31:0] exp_rd;
        exp_rd = exp_read(reg_raddr);
        if (dac_data_ready !== m_ready) begin
            $display("error: dac_data_ready got %h expected %h", dac_data_ready, m_ready);
            ready_errs++;
        end
        if (dac_cmd !== m_cmd) begin
            $display("error: dac_cmd got %h expected %h", dac_cmd, m_cmd);
            cmd_errs++;
        end
        if (safety_amp_disable !== m_trip) begin
            $display("error: safety_amp_disable got %h expected %h", safety_amp_disable, m_trip);
            dis_errs++;
        end
        if (reg_rdata !== exp_rd) begin
            $display("error: reg_rdata at %h got %h expected %h", reg_raddr, reg_rdata, exp_rd);
            rd_errs++;
        end
        if (dac_data_ready)
            pulse_cnt++;
        trips_seen |= safety_amp_disable;
    endtask

    initial begin
        int total;
        rst_n           = 1'b0;
        wr              = '0;
        reg_raddr       = '0;
        dac_busy        = 1'b0;
        adc_strobe      = 1'b0;
        adc_data        = '0;
        amp_disable_pin = '0;
        pwr_enable_cmd  = 1'b0;
        amp_enable_cmd  = '0;
        repeat (2) @(posedge sysclk);
        @(negedge sysclk);
        rst_n = 1'b1;
        for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
            check_outputs();
            drive_inputs(cyc >= N_CYCLES / 2);
            step_model();
            @(negedge sysclk);
        end
        check_outputs();
        if (pulse_cnt == 0) begin
            $display("no dac_data_ready pulse was seen during the run");
            other_errs++;
        end
        if (trips_seen == '0) begin
            $display("no axis ever tripped its safety disable");
            other_errs++;
        end
        total = ready_errs + cmd_errs + dis_errs + rd_errs + other_errs;
        $display("errors: ready %0d, cmd %0d, disable %0d, rdata %0d, other %0d",
                 ready_errs, cmd_errs, dis_errs, rd_errs, other_errs);
        if (total == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+logic
logic/qla_reg_pkg.sv
logic/qla_motor_pkg.sv
logic/cur_cmd_bank.sv
logic/board_feedback.sv
logic/safety_monitor.sv
logic/chan_read_mux.sv
logic/qla_motor_top.sv
dv/qla_motor_assert.sv
dv/tb_qla_motor.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_qla_motor -f sim.f -o tb_qla_motor
	./obj_dir/tb_qla_motor | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
